// ==== logic/ttc_settings.svh ====
`ifndef TTC_SETTINGS_SVH
`define TTC_SETTINGS_SVH

// Counter, interval and match register width
`define TTC_CNT_W 16

// Prescale value field in clock control
`define TTC_PSC_W 4

// APB byte address width
`define TTC_ADDR_W 6

`endif

// ==== logic/ttc_intr_pkg.sv ====
`default_nettype none

package ttc_intr_pkg;

  // Width of the interrupt vector
  localparam int intr_n = 5;

  // Bit 0 is overflow, match bits sit at the top
  typedef struct packed {
    logic [3:1] match;    // One per match register
    logic       interval; // Interval mode wrap
    logic       overflow; // Overflow mode wrap
  } intr_vec_t;

endpackage

`default_nettype wire

// ==== logic/ttc_reg_pkg.sv ====
`default_nettype none
`include "ttc_settings.svh"

package ttc_reg_pkg;

  // --------------------------------------------------
  // Register map, byte offsets
  // --------------------------------------------------
  localparam logic [`TTC_ADDR_W-1:0] addr_clk_ctrl    = 6'h00; // Prescale enable and value
  localparam logic [`TTC_ADDR_W-1:0] addr_cntr_ctrl   = 6'h04; // Counter control word
  localparam logic [`TTC_ADDR_W-1:0] addr_interval    = 6'h08;
  localparam logic [`TTC_ADDR_W-1:0] addr_match_1     = 6'h0C;
  localparam logic [`TTC_ADDR_W-1:0] addr_match_2     = 6'h10;
  localparam logic [`TTC_ADDR_W-1:0] addr_match_3     = 6'h14;
  localparam logic [`TTC_ADDR_W-1:0] addr_count_val   = 6'h18; // Read only
  localparam logic [`TTC_ADDR_W-1:0] addr_intr_status = 6'h1C; // Read only, clear on read
  localparam logic [`TTC_ADDR_W-1:0] addr_intr_enable = 6'h20;

  // Implemented bits of the control word
  localparam int cntr_ctrl_bits = 7;

  // Field view, bit 0 at the bottom
  typedef struct packed {
    logic [8:0] pad;           // Reads as zero
    logic       wave_pol;      // Kept for readback only
    logic       wave_en_n;     // Kept for readback only
    logic       restart;       // Self clearing
    logic       match_mode;
    logic       decrement;
    logic       interval_mode; // 1 interval, 0 overflow
    logic       disable_n;     // Counter held while set
  } cntr_ctrl_t;

  // Bus word and decoded fields share one register
  typedef union packed {
    logic [`TTC_CNT_W-1:0] raw;
    cntr_ctrl_t            f;
  } cntr_ctrl_u;

  localparam logic [`TTC_CNT_W-1:0] cntr_ctrl_rst = 16'h0001; // Disabled out of reset

endpackage

`default_nettype wire

// ==== logic/ttc_cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ttc_settings.svh"

interface ttc_cfg_if;

  // Decoder to counter
  logic [`TTC_CNT_W-1:0]   wdata;        // Shared write data
  logic                    ctrl_sel;     // Control word write strobe
  logic                    interval_sel;
  logic [3:1]              match_sel;    // One strobe per match register

  // Counter to decoder, register contents for readback
  ttc_reg_pkg::cntr_ctrl_u ctrl;
  logic [`TTC_CNT_W-1:0]   interval;
  logic [`TTC_CNT_W-1:0]   match_1;
  logic [`TTC_CNT_W-1:0]   match_2;
  logic [`TTC_CNT_W-1:0]   match_3;
  logic [`TTC_CNT_W-1:0]   count_val;    // Live count

  modport decoder (output wdata, ctrl_sel, interval_sel, match_sel,
                   input  ctrl, interval, match_1, match_2, match_3, count_val);

  modport counter (input  wdata, ctrl_sel, interval_sel, match_sel,
                   output ctrl, interval, match_1, match_2, match_3, count_val);

endinterface

`default_nettype wire

// ==== logic/ttc_apb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ttc_settings.svh"

module ttc_apb_decode (
  input  wire logic                    pclk16,
  input  wire logic                    n_p_reset16,
  input  wire logic                    psel,
  input  wire logic                    penable,
  input  wire logic                    pwrite,
  input  wire logic [`TTC_ADDR_W-1:0]  paddr,
  input  wire logic [`TTC_CNT_W-1:0]   pwdata,
  output logic [`TTC_CNT_W-1:0]        prdata,
  ttc_cfg_if.decoder                   cfg,
  input  wire logic [`TTC_PSC_W:0]     clk_ctrl,     // Prescaler readback
  input  wire ttc_intr_pkg::intr_vec_t intr_status,
  input  wire ttc_intr_pkg::intr_vec_t intr_enable,
  output logic                         clk_ctrl_sel,
  output logic                         intr_enable_sel,
  output logic                         rd_clr        // Status read in progress
);

  logic setup_q; // Setup phase seen last cycle
  logic access;  // Single access cycle of a transfer
  logic wr_en;
  logic rd_en;

  // --------------------------------------------------
  // Transfer phase tracking
  // --------------------------------------------------
  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
      setup_q <= 1'b0;
    else
      setup_q <= psel & ~penable;
  end

  assign access = psel & penable & setup_q; // One strobe per transfer
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;

  // Write strobes
  assign cfg.wdata        = pwdata;
  assign clk_ctrl_sel     = wr_en & (paddr == ttc_reg_pkg::addr_clk_ctrl);
  assign cfg.ctrl_sel     = wr_en & (paddr == ttc_reg_pkg::addr_cntr_ctrl);
  assign cfg.interval_sel = wr_en & (paddr == ttc_reg_pkg::addr_interval);
  assign cfg.match_sel[1] = wr_en & (paddr == ttc_reg_pkg::addr_match_1);
  assign cfg.match_sel[2] = wr_en & (paddr == ttc_reg_pkg::addr_match_2);
  assign cfg.match_sel[3] = wr_en & (paddr == ttc_reg_pkg::addr_match_3);
  assign intr_enable_sel  = wr_en & (paddr == ttc_reg_pkg::addr_intr_enable);

  // Status clears at the end of its read
  assign rd_clr = rd_en & (paddr == ttc_reg_pkg::addr_intr_status);

  // --------------------------------------------------
  // Read data mux, narrow registers zero filled
  // --------------------------------------------------
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (paddr)
        ttc_reg_pkg::addr_clk_ctrl:    prdata = {{(`TTC_CNT_W-`TTC_PSC_W-1){1'b0}}, clk_ctrl};
        ttc_reg_pkg::addr_cntr_ctrl:   prdata = cfg.ctrl.raw;
        ttc_reg_pkg::addr_interval:    prdata = cfg.interval;
        ttc_reg_pkg::addr_match_1:     prdata = cfg.match_1;
        ttc_reg_pkg::addr_match_2:     prdata = cfg.match_2;
        ttc_reg_pkg::addr_match_3:     prdata = cfg.match_3;
        ttc_reg_pkg::addr_count_val:   prdata = cfg.count_val;
        ttc_reg_pkg::addr_intr_status:
          prdata = {{(`TTC_CNT_W-ttc_intr_pkg::intr_n){1'b0}}, intr_status};
        ttc_reg_pkg::addr_intr_enable:
          prdata = {{(`TTC_CNT_W-ttc_intr_pkg::intr_n){1'b0}}, intr_enable};
        default:                       prdata = '0; // Unmapped reads zero
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/ttc_prescaler.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ttc_settings.svh"

module ttc_prescaler (
  input  wire logic                  pclk16,
  input  wire logic                  n_p_reset16,
  input  wire logic                  clk_ctrl_sel,
  input  wire logic [`TTC_CNT_W-1:0] wdata,
  output logic [`TTC_PSC_W:0]        clk_ctrl,   // Bit 0 enable, value above
  output logic                       count_en
);

  logic                  psc_en;
  logic [`TTC_PSC_W-1:0] psc_val; // Divide by psc_val + 1
  logic [`TTC_PSC_W-1:0] psc_cnt; // Cycles left until next pulse

  assign psc_en  = clk_ctrl[0];
  assign psc_val = clk_ctrl[`TTC_PSC_W:1];

  // Clock control register
  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
      clk_ctrl <= '0;
    else if (clk_ctrl_sel)
      clk_ctrl <= wdata[`TTC_PSC_W:0];
  end

  // --------------------------------------------------
  // Down counter, pulse on reaching zero
  // --------------------------------------------------
  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
    begin
      psc_cnt  <= '0;
      count_en <= 1'b0;
    end
    else if (!psc_en || (psc_cnt == '0))
    begin
      psc_cnt  <= psc_val; // Reload, also held while bypassed
      count_en <= 1'b1;
    end
    else
    begin
      psc_cnt  <= psc_cnt - 1'b1;
      count_en <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== logic/ttc_counter_lite.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ttc_settings.svh"

module ttc_counter_lite (
  input  wire logic               pclk16,
  input  wire logic               n_p_reset16,
  input  wire logic               count_en,   // From prescaler
  ttc_cfg_if.counter              cfg,
  output ttc_intr_pkg::intr_vec_t raw_intr    // Level, not sticky
);

  localparam logic [`TTC_CNT_W-1:0] cnt_max = '1;

  ttc_reg_pkg::cntr_ctrl_t ctrl;         // Field view of the control word
  logic [`TTC_CNT_W-1:0]   wrap_top;     // Upper end of the count range
  logic [`TTC_CNT_W-1:0]   count_next;
  logic                    counting;     // Has counted since last restart
  logic                    restart_pend; // Restart taken, bit to clear
  logic                    active;
  logic                    at_zero;

  assign ctrl = cfg.ctrl.f;

  // --------------------------------------------------
  // Register writes
  // --------------------------------------------------
  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
    begin
      cfg.ctrl.raw <= ttc_reg_pkg::cntr_ctrl_rst;
      cfg.interval <= '0;
      cfg.match_1  <= '0;
      cfg.match_2  <= '0;
      cfg.match_3  <= '0;
    end
    else
    begin
      if (cfg.ctrl_sel)
        cfg.ctrl.raw <= {{(`TTC_CNT_W-ttc_reg_pkg::cntr_ctrl_bits){1'b0}},
                         cfg.wdata[ttc_reg_pkg::cntr_ctrl_bits-1:0]};
      else if (restart_pend)
        cfg.ctrl.f.restart <= 1'b0; // Restart lasts one count

      if (cfg.interval_sel)
        cfg.interval <= cfg.wdata;
      if (cfg.match_sel[1])
        cfg.match_1 <= cfg.wdata;
      if (cfg.match_sel[2])
        cfg.match_2 <= cfg.wdata;
      if (cfg.match_sel[3])
        cfg.match_3 <= cfg.wdata;
    end
  end

  // --------------------------------------------------
  // Next count for the four modes
  // --------------------------------------------------
  assign wrap_top = ctrl.interval_mode ? cfg.interval : cnt_max; // Interval assumed static

  always_comb
  begin
    count_next = cfg.count_val; // Hold when disabled
    if (ctrl.restart)
      count_next = ctrl.decrement ? wrap_top : '0; // Start value
    else if (!ctrl.disable_n)
    begin
      if (ctrl.decrement)
        count_next = (cfg.count_val == '0) ? wrap_top : cfg.count_val - 1'b1;
      else
        count_next = (cfg.count_val == wrap_top) ? '0 : cfg.count_val + 1'b1;
    end
  end

  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
    begin
      cfg.count_val <= '0;
      counting      <= 1'b0;
      restart_pend  <= 1'b0;
    end
    else if (count_en)
    begin
      cfg.count_val <= count_next;
      if (ctrl.restart)
      begin
        counting     <= 1'b0;
        restart_pend <= 1'b1;
      end
      else
      begin
        if (!ctrl.disable_n)
          counting <= 1'b1;
        restart_pend <= 1'b0;
      end
    end
  end

  // Raw levels only while really counting
  assign active  = counting & ~ctrl.restart & ~ctrl.disable_n;
  assign at_zero = (cfg.count_val == '0);

  always_comb
  begin
    raw_intr.overflow = active & ~ctrl.interval_mode & at_zero;
    raw_intr.interval = active & ctrl.interval_mode & at_zero;
    raw_intr.match[1] = active & ctrl.match_mode & (cfg.count_val == cfg.match_1);
    raw_intr.match[2] = active & ctrl.match_mode & (cfg.count_val == cfg.match_2);
    raw_intr.match[3] = active & ctrl.match_mode & (cfg.count_val == cfg.match_3);
  end

endmodule

`default_nettype wire

// ==== logic/ttc_intr_status.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ttc_settings.svh"

module ttc_intr_status (
  input  wire logic                    pclk16,
  input  wire logic                    n_p_reset16,
  input  wire ttc_intr_pkg::intr_vec_t raw_intr,
  input  wire logic                    intr_enable_sel,
  input  wire logic [`TTC_CNT_W-1:0]   wdata,
  input  wire logic                    rd_clr,        // Status register being read
  output ttc_intr_pkg::intr_vec_t      intr_status,
  output ttc_intr_pkg::intr_vec_t      intr_enable,
  output logic                         irq
);

  // --------------------------------------------------
  // Sticky status, a new level beats the clear
  // --------------------------------------------------
  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
      intr_status <= '0;
    else if (rd_clr)
      intr_status <= raw_intr;
    else
      intr_status <= intr_status | raw_intr;
  end

  // Enable mask
  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
      intr_enable <= '0;
    else if (intr_enable_sel)
      intr_enable <= wdata[ttc_intr_pkg::intr_n-1:0];
  end

  // Registered interrupt line
  always_ff @(posedge pclk16 or negedge n_p_reset16)
  begin
    if (!n_p_reset16)
      irq <= 1'b0;
    else
      irq <= |(intr_status & intr_enable);
  end

endmodule

`default_nettype wire

// ==== logic/ttc_timer_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ttc_settings.svh"

module ttc_timer_top (
  input  wire logic                   pclk16,
  input  wire logic                   n_p_reset16,
  input  wire logic                   psel,
  input  wire logic                   penable,
  input  wire logic                   pwrite,
  input  wire logic [`TTC_ADDR_W-1:0] paddr,
  input  wire logic [`TTC_CNT_W-1:0]  pwdata,
  output logic [`TTC_CNT_W-1:0]       prdata,
  output logic                        irq
);

  ttc_cfg_if cfg_if ();  // Decoder to counter registers

  logic [`TTC_PSC_W:0]     clk_ctrl;
  logic                    clk_ctrl_sel;
  logic                    intr_enable_sel;
  logic                    rd_clr;
  logic                    count_en;
  ttc_intr_pkg::intr_vec_t raw_intr;
  ttc_intr_pkg::intr_vec_t intr_status;
  ttc_intr_pkg::intr_vec_t intr_enable;

  // --------------------------------------------------
  // Bus side
  // --------------------------------------------------
  ttc_apb_decode i_ttc_apb_decode (
    .pclk16          (pclk16),
    .n_p_reset16     (n_p_reset16),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .cfg             (cfg_if.decoder),
    .clk_ctrl        (clk_ctrl),
    .intr_status     (intr_status),
    .intr_enable     (intr_enable),
    .clk_ctrl_sel    (clk_ctrl_sel),
    .intr_enable_sel (intr_enable_sel),
    .rd_clr          (rd_clr)
  );

  ttc_prescaler i_ttc_prescaler (
    .pclk16       (pclk16),
    .n_p_reset16  (n_p_reset16),
    .clk_ctrl_sel (clk_ctrl_sel),
    .wdata        (cfg_if.wdata),
    .clk_ctrl     (clk_ctrl),
    .count_en     (count_en)
  );

  // --------------------------------------------------
  // Counter and interrupts
  // --------------------------------------------------
  ttc_counter_lite i_ttc_counter_lite (
    .pclk16      (pclk16),
    .n_p_reset16 (n_p_reset16),
    .count_en    (count_en),
    .cfg         (cfg_if.counter),
    .raw_intr    (raw_intr)
  );

  ttc_intr_status i_ttc_intr_status (
    .pclk16          (pclk16),
    .n_p_reset16     (n_p_reset16),
    .raw_intr        (raw_intr),
    .intr_enable_sel (intr_enable_sel),
    .wdata           (cfg_if.wdata),
    .rd_clr          (rd_clr),
    .intr_status     (intr_status),
    .intr_enable     (intr_enable),
    .irq             (irq)
  );

endmodule

`default_nettype wire

// ==== verification/tb_ttc_timer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ttc_settings.svh"

module tb_ttc_timer;

  localparam int clk_period      = 4;     // ns
  localparam int reset_cycles    = 10;
  localparam int longest_cycles  = 12500; // Longest run, rounded up
  localparam int watchdog_cycles = 4 * longest_cycles;
  localparam int restart_limit   = 40;    // Cycles for restart to self clear
  localparam int step_reads      = 120;   // Count reads per mode
  localparam int read_gap        = 3;     // Setup, access and idle cycle per read
  localparam int step_gap        = 16;    // Prescale 15
  localparam int min_steps       = (read_gap * step_reads) / step_gap;

  logic                   pclk16;
  logic                   n_p_reset16;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`TTC_ADDR_W-1:0] paddr;
  logic [`TTC_CNT_W-1:0]  pwdata;
  logic [`TTC_CNT_W-1:0]  prdata;
  logic                   irq;

  integer seed;
  int     errors    = 0;
  int     checks    = 0;
  int     cycle_cnt = 0;

  // Pending comparisons, filled by the test sequence
  string                 name_q[$];
  logic [`TTC_CNT_W-1:0] exp_q[$];
  logic [`TTC_CNT_W-1:0] act_q[$];

  ttc_timer_top i_ttc_timer_top (
    .pclk16      (pclk16),
    .n_p_reset16 (n_p_reset16),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .irq         (irq)
  );

  initial
  begin
    pclk16 = 1'b0;
    forever #(clk_period / 2) pclk16 = ~pclk16;
  end

  always @(posedge pclk16) cycle_cnt <= cycle_cnt + 1; // Time base for restart limit

  // --------------------------------------------------
  // APB transfers, setup then one access cycle
  // --------------------------------------------------
  task automatic apb_write(input logic [`TTC_ADDR_W-1:0] addr,
                           input logic [`TTC_CNT_W-1:0] data);
    @(negedge pclk16);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge pclk16);
    penable = 1'b1;   // Access, register takes data at next rise
    @(negedge pclk16);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`TTC_ADDR_W-1:0] addr,
                          output logic [`TTC_CNT_W-1:0] data);
    @(negedge pclk16);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge pclk16);
    penable = 1'b1;
    #1;
    data    = prdata; // Mid access, well before the closing edge
    @(negedge pclk16);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic queue_check(input string name, input logic [`TTC_CNT_W-1:0] exp,
                             input logic [`TTC_CNT_W-1:0] act);
    name_q.push_back(name);
    exp_q.push_back(exp);
    act_q.push_back(act);
  endtask

  task automatic read_expect(input string name, input logic [`TTC_ADDR_W-1:0] addr,
                             input logic [`TTC_CNT_W-1:0] exp);
    logic [`TTC_CNT_W-1:0] word;
    apb_read(addr, word);
    queue_check(name, exp, word);
  endtask

  function automatic logic [`TTC_CNT_W-1:0] next_random();
    logic [31:0] r;
    r = $random(seed);
    return r[`TTC_CNT_W-1:0];
  endfunction

  // Control word from its fields
  function automatic logic [`TTC_CNT_W-1:0] make_ctrl(input logic interval_mode,
      input logic decrement, input logic match_mode, input logic restart,
      input logic disable_n);
    ttc_reg_pkg::cntr_ctrl_u w;
    w.raw             = '0;
    w.f.interval_mode = interval_mode;
    w.f.decrement     = decrement;
    w.f.match_mode    = match_mode;
    w.f.restart       = restart;
    w.f.disable_n     = disable_n;
    return w.raw;
  endfunction

  // Status register image, zero filled above the vector
  function automatic logic [`TTC_CNT_W-1:0] status_word(input logic ovf, input logic intv,
                                                        input logic [3:1] match);
    ttc_intr_pkg::intr_vec_t v;
    v.overflow = ovf;
    v.interval = intv;
    v.match    = match;
    return {{(`TTC_CNT_W-ttc_intr_pkg::intr_n){1'b0}}, v};
  endfunction

  // --------------------------------------------------
  // Reference model of the count sequence
  // --------------------------------------------------
  function automatic logic [`TTC_CNT_W-1:0] count_top(input ttc_reg_pkg::cntr_ctrl_u ctrl,
                                                      input logic [`TTC_CNT_W-1:0] interval);
    return ctrl.f.interval_mode ? interval : {`TTC_CNT_W{1'b1}};
  endfunction

  function automatic logic [`TTC_CNT_W-1:0] restart_value(input ttc_reg_pkg::cntr_ctrl_u ctrl,
                                                          input logic [`TTC_CNT_W-1:0] interval);
    return ctrl.f.decrement ? count_top(ctrl, interval) : '0; // Down counts start at the top
  endfunction

  function automatic logic [`TTC_CNT_W-1:0] ref_next_count(input ttc_reg_pkg::cntr_ctrl_u ctrl,
      input logic [`TTC_CNT_W-1:0] interval, input logic [`TTC_CNT_W-1:0] count);
    logic [`TTC_CNT_W-1:0] top;
    top = count_top(ctrl, interval);
    if (ctrl.f.disable_n)
      return count;                                      // Held
    if (ctrl.f.decrement)
      return (count == '0) ? top : count - 1'b1;
    return (count == top) ? '0 : count + 1'b1;
  endfunction

  // Compare process, drains the queue every cycle
  initial
  begin : compare_proc
    string                 name;
    logic [`TTC_CNT_W-1:0] exp;
    logic [`TTC_CNT_W-1:0] act;
    forever
    begin
      @(posedge pclk16);
      while (exp_q.size() > 0)
      begin
        name = name_q.pop_front();
        exp  = exp_q.pop_front();
        act  = act_q.pop_front();
        checks++;
        if (act !== exp)
        begin
          $display("error %s: expected %h, actual %h", name, exp, act);
          errors++;
        end
      end
    end
  end

  // Poll the control word until restart drops
  task automatic wait_restart_clear(input string tag);
    ttc_reg_pkg::cntr_ctrl_u rd;
    logic [`TTC_CNT_W-1:0]   word;
    int                      start;
    start = cycle_cnt;
    apb_read(ttc_reg_pkg::addr_cntr_ctrl, word);
    rd.raw = word;
    while (rd.f.restart && ((cycle_cnt - start) <= restart_limit))
    begin
      apb_read(ttc_reg_pkg::addr_cntr_ctrl, word);
      rd.raw = word;
    end
    if (rd.f.restart)
    begin
      $display("restart bit in %s still set after %0d cycles", tag, restart_limit);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // Test sequences
  // --------------------------------------------------
  task automatic reset_values();
    read_expect("reset clk_ctrl", ttc_reg_pkg::addr_clk_ctrl, 16'h0000);
    read_expect("reset cntr_ctrl", ttc_reg_pkg::addr_cntr_ctrl, 16'h0001); // Disabled
    read_expect("reset interval", ttc_reg_pkg::addr_interval, 16'h0000);
    read_expect("reset match_1", ttc_reg_pkg::addr_match_1, 16'h0000);
    read_expect("reset match_2", ttc_reg_pkg::addr_match_2, 16'h0000);
    read_expect("reset match_3", ttc_reg_pkg::addr_match_3, 16'h0000);
    read_expect("reset count_val", ttc_reg_pkg::addr_count_val, 16'h0000);
    read_expect("reset intr_status", ttc_reg_pkg::addr_intr_status, 16'h0000);
    read_expect("reset intr_enable", ttc_reg_pkg::addr_intr_enable, 16'h0000);
    queue_check("reset irq", 16'h0000, {15'd0, irq});
  endtask

  task automatic register_readback();
    logic [`TTC_CNT_W-1:0] v;
    v = next_random();
    apb_write(ttc_reg_pkg::addr_clk_ctrl, v);
    read_expect("readback clk_ctrl", ttc_reg_pkg::addr_clk_ctrl, v & 16'h001F); // 5 bits
    v = next_random();
    apb_write(ttc_reg_pkg::addr_interval, v);
    read_expect("readback interval", ttc_reg_pkg::addr_interval, v);
    v = next_random();
    apb_write(ttc_reg_pkg::addr_match_1, v);
    read_expect("readback match_1", ttc_reg_pkg::addr_match_1, v);
    v = next_random();
    apb_write(ttc_reg_pkg::addr_match_2, v);
    read_expect("readback match_2", ttc_reg_pkg::addr_match_2, v);
    v = next_random();
    apb_write(ttc_reg_pkg::addr_match_3, v);
    read_expect("readback match_3", ttc_reg_pkg::addr_match_3, v);
    v = next_random();
    apb_write(ttc_reg_pkg::addr_intr_enable, v);
    read_expect("readback intr_enable", ttc_reg_pkg::addr_intr_enable, v & 16'h001F);
  endtask

  task automatic count_stepping(input logic im, input logic dec);
    ttc_reg_pkg::cntr_ctrl_u ctrl;
    logic [`TTC_CNT_W-1:0]   interval;
    logic [`TTC_CNT_W-1:0]   prev;
    logic [`TTC_CNT_W-1:0]   act;
    logic [`TTC_CNT_W-1:0]   exp;
    string                   tag;
    int                      i;
    int                      steps;
    tag      = $sformatf("step im%0d dec%0d", im, dec);
    steps    = 0;
    interval = 16'd8 + (next_random() & 16'h000F); // Short, so wraps are seen
    ctrl.raw = make_ctrl(im, dec, 1'b0, 1'b0, 1'b0);
    apb_write(ttc_reg_pkg::addr_clk_ctrl, 16'h001F); // Prescale 15, every 16 cycles
    apb_write(ttc_reg_pkg::addr_interval, interval);
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(im, dec, 1'b0, 1'b1, 1'b0));
    wait_restart_clear(tag);
    apb_read(ttc_reg_pkg::addr_count_val, prev);
    queue_check({tag, " start"}, restart_value(ctrl, interval), prev);
    for (i = 0; i < step_reads; i++)
    begin
      apb_read(ttc_reg_pkg::addr_count_val, act);
      // Same value or exactly one step on
      exp = (act == prev) ? prev : ref_next_count(ctrl, interval, prev);
      queue_check(tag, exp, act);
      if (act != prev)
        steps++;
      if (im && (act > interval))
      begin
        $display("count %h above interval %h in %s", act, interval, tag);
        errors++;
      end
      prev = act;
    end
    // One step per prescale period over the whole read window
    if ((steps < min_steps) || (steps > min_steps + 1))
    begin
      $display("error %s steps: expected %0d to %0d, actual %0d", tag, min_steps,
               min_steps + 1, steps);
      errors++;
    end
  endtask

  task automatic wrap_interrupts();
    logic [`TTC_CNT_W-1:0] word;
    logic [`TTC_CNT_W-1:0] interval;
    logic                  irq_seen;
    int                    wait_cycles;
    int                    i;
    apb_write(ttc_reg_pkg::addr_clk_ctrl, 16'h0000);  // Count every cycle
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
    apb_write(ttc_reg_pkg::addr_intr_enable, 16'h0001); // Overflow only
    apb_read(ttc_reg_pkg::addr_intr_status, word);     // Drop stale bits

    // Start near zero, then leave interval mode so the wrap is short
    apb_write(ttc_reg_pkg::addr_interval, 16'd200);
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b1, 1'b1, 1'b0, 1'b1, 1'b0));
    wait_restart_clear("overflow restart");
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
    repeat (250) @(negedge pclk16);
    queue_check("overflow irq enabled", 16'h0001, {15'd0, irq});
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
    read_expect("overflow status", ttc_reg_pkg::addr_intr_status,
                status_word(1'b1, 1'b0, 3'b000));
    read_expect("overflow status cleared", ttc_reg_pkg::addr_intr_status, 16'h0000);
    queue_check("irq after clear", 16'h0000, {15'd0, irq});

    // Interval wrap with its bit masked
    interval    = 16'd30 + (next_random() & 16'h000F);
    wait_cycles = 2 * int'(interval) + 40;
    irq_seen    = 1'b0;
    apb_write(ttc_reg_pkg::addr_interval, interval);
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
    for (i = 0; i < wait_cycles; i++)
    begin
      @(negedge pclk16);
      if (irq)
        irq_seen = 1'b1;
    end
    queue_check("interval irq masked", 16'h0000, {15'd0, irq_seen});
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
    read_expect("interval status", ttc_reg_pkg::addr_intr_status,
                status_word(1'b0, 1'b1, 3'b000));
    read_expect("interval status cleared", ttc_reg_pkg::addr_intr_status, 16'h0000);
  endtask

  task automatic match_interrupts();
    logic [`TTC_CNT_W-1:0] word;
    apb_write(ttc_reg_pkg::addr_interval, 16'd60);
    apb_write(ttc_reg_pkg::addr_match_1, 16'd1 + (next_random() & 16'h000F));  // 1..16
    apb_write(ttc_reg_pkg::addr_match_2, 16'd20 + (next_random() & 16'h000F)); // 20..35
    apb_write(ttc_reg_pkg::addr_match_3, 16'd40 + (next_random() & 16'h000F)); // 40..55
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b1, 1'b0, 1'b1, 1'b1, 1'b0));
    repeat (100) @(negedge pclk16);
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b1, 1'b0, 1'b1, 1'b0, 1'b1));
    apb_read(ttc_reg_pkg::addr_intr_status, word);
    queue_check("match bits set", status_word(1'b0, 1'b0, 3'b111),
                word & status_word(1'b0, 1'b0, 3'b111));

    // Same run without match mode
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
    repeat (100) @(negedge pclk16);
    apb_write(ttc_reg_pkg::addr_cntr_ctrl, make_ctrl(1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
    apb_read(ttc_reg_pkg::addr_intr_status, word);
    queue_check("match bits clear", 16'h0000, word & status_word(1'b0, 1'b0, 3'b111));
  endtask

  // --------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------
  initial
  begin : main_seq
    int mode;
    seed        = 32'hcd4c;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    n_p_reset16 = 1'b0;
    repeat (reset_cycles) @(negedge pclk16);
    n_p_reset16 = 1'b1;

    reset_values();
    register_readback();
    for (mode = 0; mode < 4; mode++)
      count_stepping(mode[1], mode[0]); // Interval mode, decrement
    wrap_interrupts();
    match_interrupts();

    repeat (2) @(negedge pclk16); // Let the queue drain
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial
  begin : watchdog
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ttc_timer.f ====
+incdir+logic
logic/ttc_intr_pkg.sv
logic/ttc_reg_pkg.sv
logic/ttc_cfg_if.sv
logic/ttc_apb_decode.sv
logic/ttc_prescaler.sv
logic/ttc_counter_lite.sv
logic/ttc_intr_status.sv
logic/ttc_timer_top.sv
verification/tb_ttc_timer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the timer testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f ttc_timer.f --top-module tb_ttc_timer -Mdir "$build_dir"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_ttc_timer" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# Verdict comes from the log
if grep -q "^>>> PASS$" "$log_file"; then
  exit 0
fi
echo "pass message not found in $log_file"
exit 1
